/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

  // --------------------
  // Major opcodes
  // --------------------

  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // --------------------
  // funct3 and funct7
  // --------------------

  // ALU operations, shared by OP_IMM and OP_REG
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  // Access size, only full words are supported
  localparam logic [2:0] F3_WORD = 3'b010;

  // Selects SUB over ADD in OP_REG
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // --------------------
  // Fixed instruction words
  // --------------------

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP    = 32'h0000_0013;
  localparam logic [31:0] I_EBREAK = 32'h0010_0073;

endpackage

/* common/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // ALU operation, PASS_B forwards operand b for LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_t;

  // --------------------
  // Inter-stage bundles
  // --------------------

  // IF -> ID
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } if_id_t;

  // ID -> EX, decoded controls plus operands
  typedef struct packed {
    logic        valid;
    alu_op_t     alu_op;
    logic [4:0]  rd;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jump;
    logic        is_halt;
    logic        alu_b_imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] pc;
  } id_ex_t;

  // EX -> ID register write
  typedef struct packed {
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  // EX -> IF PC redirect
  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } redirect_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f rv_core.f \
  || { echo "Build failed"; exit 1; }

./obj_dir/Vrv_core_tb > sim.log 2>&1
cat sim.log

! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
  || { echo "Simulation reported failure"; exit 1; }

/* rv_core.f */
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
source/rv_stage_if.sv
source/rv_stage_id.sv
source/rv_stage_ex.sv
source/rv_core.sv
testbench/rv_core_tb.sv

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,

  // Instruction memory
  output logic        imem_ren,
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,

  // Data memory read
  output logic        dmem_ren,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,

  // Data memory write
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,

  output logic        ebreak
);

  // --------------------
  // Stage bundles
  // --------------------

  rv_pipe_pkg::if_id_t    if_id;
  rv_pipe_pkg::id_ex_t    id_ex;
  rv_pipe_pkg::wb_t       wb;
  rv_pipe_pkg::redirect_t redirect;

  logic halted;
  logic flush;

  rv_stage_if #(
    .RESET_PC (RESET_PC)
  ) u_if (
    .clk        (clk),
    .reset      (reset),
    .redirect   (redirect),
    .halted     (halted),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .if_id      (if_id),
    .flush      (flush)
  );

  rv_stage_id u_id (
    .clk    (clk),
    .reset  (reset),
    .if_id  (if_id),
    .flush  (flush),
    .halted (halted),
    .wb     (wb),
    .id_ex  (id_ex)
  );

  rv_stage_ex u_ex (
    .clk        (clk),
    .reset      (reset),
    .id_ex      (id_ex),
    .wb         (wb),
    .redirect   (redirect),
    .halted     (halted),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

endmodule

/* source/rv_stage_ex.sv */
`timescale 1ns/1ps

module rv_stage_ex (
  input  logic                   clk,
  input  logic                   reset,

  input  rv_pipe_pkg::id_ex_t    id_ex,

  output rv_pipe_pkg::wb_t       wb,
  output rv_pipe_pkg::redirect_t redirect,
  output logic                   halted,

  // Data memory, combinational read
  output logic                   dmem_ren,
  output logic [31:0]            dmem_raddr,
  input  logic [31:0]            dmem_rdata,

  // Data memory, write taken on the rising edge
  output logic                   dmem_we,
  output logic [31:0]            dmem_waddr,
  output logic [31:0]            dmem_wdata,

  output logic                   ebreak
);

  logic        active;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] pc_plus4;
  logic        branch_taken;

  // Nothing younger than EBREAK takes effect
  assign active = id_ex.valid && !halted;

  // --------------------
  // ALU
  // --------------------

  assign alu_b = id_ex.alu_b_imm ? id_ex.imm : id_ex.rs2_data;

  always_comb begin
    case (id_ex.alu_op)
      rv_pipe_pkg::ALU_ADD:    alu_result = id_ex.rs1_data + alu_b;
      rv_pipe_pkg::ALU_SUB:    alu_result = id_ex.rs1_data - alu_b;
      rv_pipe_pkg::ALU_AND:    alu_result = id_ex.rs1_data & alu_b;
      rv_pipe_pkg::ALU_OR:     alu_result = id_ex.rs1_data | alu_b;
      rv_pipe_pkg::ALU_XOR:    alu_result = id_ex.rs1_data ^ alu_b;
      rv_pipe_pkg::ALU_SLT:    alu_result = {31'd0, $signed(id_ex.rs1_data) < $signed(alu_b)};
      rv_pipe_pkg::ALU_PASS_B: alu_result = alu_b;
      default:                 alu_result = 32'd0;
    endcase
  end

  // --------------------
  // Data memory
  // --------------------

  // Address is the ALU sum rs1 + imm
  assign dmem_ren   = active && id_ex.mem_read;
  assign dmem_raddr = alu_result;
  assign dmem_we    = active && id_ex.mem_write;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = id_ex.rs2_data;

  // --------------------
  // Write-back and redirect
  // --------------------

  assign pc_plus4 = id_ex.pc + 32'd4;

  assign wb.we   = active && id_ex.reg_write;
  assign wb.rd   = id_ex.rd;
  assign wb.data = id_ex.mem_read ? dmem_rdata :
                   id_ex.is_jump  ? pc_plus4   : alu_result;

  // BNE inverts the equality test
  assign branch_taken = id_ex.is_branch &&
                        ((id_ex.rs1_data == id_ex.rs2_data) ^ id_ex.branch_ne);

  assign redirect.taken  = active && (id_ex.is_jump || branch_taken);
  assign redirect.target = id_ex.pc + id_ex.imm;

  // Halt flag, sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (active && id_ex.is_halt) begin
      halted <= 1'b1;
    end
  end

  assign ebreak = halted;

  // The decoder never marks one instruction as both load and store
  a_rw_excl: assert property (@(posedge clk) disable iff (reset) !(dmem_we && dmem_ren));

endmodule

/* source/rv_stage_id.sv */
`timescale 1ns/1ps

module rv_stage_id (
  input  logic                clk,
  input  logic                reset,

  input  rv_pipe_pkg::if_id_t if_id,
  input  logic                flush,
  input  logic                halted,
  input  rv_pipe_pkg::wb_t    wb,

  output rv_pipe_pkg::id_ex_t id_ex
);

  logic [31:0] instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;

  logic [31:0] regs [1:31];
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  rv_pipe_pkg::id_ex_t dec;

  // Bubbles decode as a plain NOP
  assign instr  = if_id.valid ? if_id.instr : rv_isa_pkg::I_NOP;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // --------------------
  // Immediates
  // --------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // --------------------
  // Register file
  // --------------------

  always_ff @(posedge clk) begin
    if (wb.we && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-through, so a result leaving EX is seen in the same cycle
  assign rs1_data = (rs1 == 5'd0) ? 32'd0 :
                    (wb.we && (wb.rd == rs1)) ? wb.data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 :
                    (wb.we && (wb.rd == rs2)) ? wb.data : regs[rs2];

  // --------------------
  // Decoder
  // --------------------

  always_comb begin
    dec           = '0;
    dec.valid     = if_id.valid && !flush;
    dec.alu_op    = rv_pipe_pkg::ALU_ADD;
    dec.rd        = instr[11:7];
    dec.rs1_data  = rs1_data;
    dec.rs2_data  = rs2_data;
    dec.imm       = imm_i;
    dec.pc        = if_id.pc;

    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        dec.alu_b_imm = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD: dec.alu_op = rv_pipe_pkg::ALU_ADD;
          rv_isa_pkg::F3_AND: dec.alu_op = rv_pipe_pkg::ALU_AND;
          rv_isa_pkg::F3_OR:  dec.alu_op = rv_pipe_pkg::ALU_OR;
          rv_isa_pkg::F3_XOR: dec.alu_op = rv_pipe_pkg::ALU_XOR;
          default:            dec.reg_write = 1'b0;
        endcase
      end
      rv_isa_pkg::OP_REG: begin
        dec.reg_write = 1'b1;
        if ((funct3 == rv_isa_pkg::F3_ADD) && (funct7 == rv_isa_pkg::F7_SUB)) begin
          dec.alu_op = rv_pipe_pkg::ALU_SUB;
        end else if (funct7 != 7'd0) begin
          dec.reg_write = 1'b0;
        end else begin
          case (funct3)
            rv_isa_pkg::F3_ADD: dec.alu_op = rv_pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_AND: dec.alu_op = rv_pipe_pkg::ALU_AND;
            rv_isa_pkg::F3_OR:  dec.alu_op = rv_pipe_pkg::ALU_OR;
            rv_isa_pkg::F3_XOR: dec.alu_op = rv_pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SLT: dec.alu_op = rv_pipe_pkg::ALU_SLT;
            default:            dec.reg_write = 1'b0;
          endcase
        end
      end
      rv_isa_pkg::OP_LUI: begin
        dec.alu_op    = rv_pipe_pkg::ALU_PASS_B;
        dec.alu_b_imm = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_u;
      end
      rv_isa_pkg::OP_LOAD: begin
        dec.alu_b_imm = 1'b1;
        dec.reg_write = (funct3 == rv_isa_pkg::F3_WORD);
        dec.mem_read  = (funct3 == rv_isa_pkg::F3_WORD);
      end
      rv_isa_pkg::OP_STORE: begin
        dec.alu_b_imm = 1'b1;
        dec.mem_write = (funct3 == rv_isa_pkg::F3_WORD);
        dec.imm       = imm_s;
      end
      rv_isa_pkg::OP_BRANCH: begin
        dec.is_branch = (funct3 == rv_isa_pkg::F3_BEQ) || (funct3 == rv_isa_pkg::F3_BNE);
        dec.branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
        dec.imm       = imm_b;
      end
      rv_isa_pkg::OP_JAL: begin
        dec.is_jump   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_j;
      end
      rv_isa_pkg::OP_SYSTEM: dec.is_halt = (instr == rv_isa_pkg::I_EBREAK);
      default: ;
    endcase

    // x0 is hardwired, so a write to it is dropped at decode
    if (dec.rd == 5'd0) begin
      dec.reg_write = 1'b0;
    end
  end

  // ID/EX register, held once the core has halted
  always_ff @(posedge clk) begin
    if (!halted) begin
      id_ex <= dec;
    end
    if (reset) begin
      id_ex.valid <= 1'b0;
    end
  end

  // No write to x0 comes back from EX
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset) wb.we |-> (wb.rd != 5'd0));

endmodule

/* source/rv_stage_if.sv */
`timescale 1ns/1ps

module rv_stage_if #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   reset,

  input  rv_pipe_pkg::redirect_t redirect,
  input  logic                   halted,

  // Instruction memory, answers in the same cycle
  output logic                   imem_ren,
  output logic [31:0]            imem_raddr,
  input  logic [31:0]            imem_rdata,

  output rv_pipe_pkg::if_id_t    if_id,
  output logic                   flush
);

  logic [31:0] pc;

  // A redirect from EX kills both younger slots
  assign flush      = redirect.taken;

  assign imem_ren   = !halted;
  assign imem_raddr = pc;

  // --------------------
  // Program counter
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (!halted) begin
      pc <= redirect.taken ? redirect.target : pc + 32'd4;
    end
  end

  // --------------------
  // IF/ID register
  // --------------------

  always_ff @(posedge clk) begin
    if (!halted) begin
      if_id.valid <= !flush;
      if_id.pc    <= pc;
      if_id.instr <= imem_rdata;
    end
    if (reset) begin
      if_id.valid <= 1'b0;
    end
  end

  // Redirect targets from EX must keep the PC word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* testbench/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [31:0] RES_BASE   = 32'h0000_0100;
  localparam logic [31:0] LOAD_ADDR  = 32'h0000_0080;
  localparam logic [31:0] GUARD_ADDR = 32'h0000_01F0;
  localparam logic [31:0] POISON     = 32'h0000_07AD;

  // Each instruction costs at most three cycles with redirect bubbles,
  // the rest covers reset and the quiet tail after ebreak
  localparam int MAX_INSTR      = 80;
  localparam int TIMEOUT_CYCLES = 5 * MAX_INSTR;

  logic        clk;
  logic        reset;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:127];

  // Expected result table, indexed by data word
  logic [31:0] exp_data  [0:127];
  bit          exp_valid [0:127];
  bit          seen      [0:127];
  string       test_name [0:127];

  logic [6:0]  wr_idx;
  logic [31:0] exp_word;
  logic        exp_here;

  int          n_instr;
  int          n_results;
  int          missing;
  int          cycle_count = 0;

  logic [11:0] imm_a, imm_b, imm_c, imm_d;
  logic [19:0] imm_u;
  logic [31:0] load_word;
  logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11, r12;
  logic [31:0] c13, c14, c15, c16, r19;
  logic [31:0] jal_pc;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

  always #20 clk = ~clk;

  // --------------------
  // Memory models
  // --------------------

  assign imem_rdata = imem[imem_raddr[7:2]];

  // Read data is only valid while dmem_ren is high
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[8:2]] : ~load_word;

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[8:2]] <= dmem_wdata;
      seen[dmem_waddr[8:2]] <= 1'b1;
    end
  end

  assign wr_idx   = dmem_waddr[8:2];
  assign exp_word = exp_data[wr_idx];
  assign exp_here = exp_valid[wr_idx] && (dmem_waddr[31:9] == 23'd0) &&
                    (dmem_waddr[1:0] == 2'b00);

  // --------------------
  // Instruction encoders
  // --------------------

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rv_isa_pkg::OP_LUI};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[n_instr] = word;
    n_instr++;
  endtask

  // Adds a SW of rs2 to the next result slot and records its expected value
  task automatic store_result(input logic [4:0] rs2, input string name,
                              input logic [31:0] value);
    int idx;
    idx = int'(RES_BASE[8:2]) + n_results;
    exp_data[idx]  = value;
    exp_valid[idx] = 1'b1;
    test_name[idx] = name;
    emit(s_type(rs2, 5'd0, 12'(idx * 4)));
    n_results++;
  endtask

  task automatic store_poison();
    emit(s_type(5'd22, 5'd0, GUARD_ADDR[11:0]));
  endtask

  // --------------------
  // Checks
  // --------------------

  a_store_value: assert property (@(negedge clk) disable iff (reset)
    (dmem_we && exp_here) |-> (dmem_wdata == exp_word))
    else begin
      $display("mismatch in %s: expected %08h, actual %08h",
               test_name[wr_idx], exp_word, dmem_wdata);
      $display("Test failed");
      $fatal(1);
    end

  a_store_addr: assert property (@(negedge clk) disable iff (reset)
    dmem_we |-> (exp_here || (dmem_waddr == GUARD_ADDR)))
    else begin
      $display("store to address %08h that expects no result", dmem_waddr);
      $display("Test failed");
      $fatal(1);
    end

  a_no_guard: assert property (@(negedge clk) disable iff (reset)
    dmem_we |-> (dmem_waddr != GUARD_ADDR))
    else begin
      $display("a squashed instruction stored to the guard address %08h", dmem_waddr);
      $display("Test failed");
      $fatal(1);
    end

  // The program holds a single load
  a_load_addr: assert property (@(negedge clk) disable iff (reset)
    dmem_ren |-> (dmem_raddr == LOAD_ADDR))
    else begin
      $display("data read from %08h, which the program never loads", dmem_raddr);
      $display("Test failed");
      $fatal(1);
    end

  a_fetch_active: assert property (@(negedge clk) disable iff (reset)
    !ebreak |-> imem_ren)
    else begin
      $display("instruction fetch disabled before ebreak");
      $display("Test failed");
      $fatal(1);
    end

  a_halt_quiet: assert property (@(negedge clk) disable iff (reset)
    ebreak |-> (!dmem_we && !imem_ren))
    else begin
      $display("store or fetch activity after ebreak");
      $display("Test failed");
      $fatal(1);
    end

  a_halt_sticky: assert property (@(negedge clk) disable iff (reset)
    $past(ebreak) |-> ebreak)
    else begin
      $display("ebreak dropped before reset");
      $display("Test failed");
      $fatal(1);
    end

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout, ebreak not seen after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1);
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    void'($urandom(14077));

    imm_a     = 12'($urandom);
    imm_b     = 12'($urandom);
    imm_c     = 12'($urandom);
    imm_d     = 12'($urandom);
    imm_u     = 20'($urandom);
    load_word = $urandom;

    // Expected values by the RV32I rules
    r1  = sext12(imm_a);
    r2  = sext12(imm_b);
    r3  = r1 & sext12(imm_c);
    r4  = r1 | sext12(imm_c);
    r5  = r2 ^ sext12(imm_d);
    r6  = r1 + r2;
    r7  = r1 - r2;
    r8  = r1 & r2;
    r9  = r1 | r2;
    r10 = r1 ^ r2;
    r11 = ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
    r12 = {imm_u, 12'd0};
    c13 = r1 + 32'd7;
    c14 = c13 + c13;
    c15 = c14 - r1;
    c16 = c15 ^ c13;
    r19 = load_word + r1;

    // Unused slots hold addi x0, x0, index
    for (int i = 0; i < 64; i++) begin
      imem[i] = i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd0, 5'd0, 12'(i));
    end
    for (int i = 0; i < 128; i++) begin
      dmem[i]      = 32'hDA7A_0000 | (i * 4);
      exp_valid[i] = 1'b0;
      seen[i]      = 1'b0;
    end
    dmem[LOAD_ADDR[8:2]] = load_word;
    n_instr   = 0;
    n_results = 0;

    // ALU block
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd1, 5'd0, imm_a));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd2, 5'd0, imm_b));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_AND, 5'd3, 5'd1, imm_c));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_OR, 5'd4, 5'd1, imm_c));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_XOR, 5'd5, 5'd2, imm_d));
    emit(r_type(7'd0, rv_isa_pkg::F3_ADD, 5'd6, 5'd1, 5'd2));
    emit(r_type(rv_isa_pkg::F7_SUB, rv_isa_pkg::F3_ADD, 5'd7, 5'd1, 5'd2));
    emit(r_type(7'd0, rv_isa_pkg::F3_AND, 5'd8, 5'd1, 5'd2));
    emit(r_type(7'd0, rv_isa_pkg::F3_OR, 5'd9, 5'd1, 5'd2));
    emit(r_type(7'd0, rv_isa_pkg::F3_XOR, 5'd10, 5'd1, 5'd2));
    emit(r_type(7'd0, rv_isa_pkg::F3_SLT, 5'd11, 5'd1, 5'd2));
    emit(u_type(5'd12, imm_u));
    store_result(5'd1, "addi", r1);
    store_result(5'd2, "addi_b", r2);
    store_result(5'd3, "andi", r3);
    store_result(5'd4, "ori", r4);
    store_result(5'd5, "xori", r5);
    store_result(5'd6, "add", r6);
    store_result(5'd7, "sub", r7);
    store_result(5'd8, "and", r8);
    store_result(5'd9, "or", r9);
    store_result(5'd10, "xor", r10);
    store_result(5'd11, "slt", r11);
    store_result(5'd12, "lui", r12);

    // Back-to-back chain, each uses the previous rd
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd13, 5'd1, 12'd7));
    emit(r_type(7'd0, rv_isa_pkg::F3_ADD, 5'd14, 5'd13, 5'd13));
    emit(r_type(rv_isa_pkg::F7_SUB, rv_isa_pkg::F3_ADD, 5'd15, 5'd14, 5'd1));
    emit(r_type(7'd0, rv_isa_pkg::F3_XOR, 5'd16, 5'd15, 5'd13));
    store_result(5'd16, "chain", c16);
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd0, 5'd1, 12'h123));
    emit(r_type(7'd0, rv_isa_pkg::F3_ADD, 5'd0, 5'd1, 5'd2));
    store_result(5'd0, "x0_write", 32'd0);

    // Load followed at once by its use
    emit(i_type(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, 5'd18, 5'd0, LOAD_ADDR[11:0]));
    emit(r_type(7'd0, rv_isa_pkg::F3_ADD, 5'd19, 5'd18, 5'd1));
    store_result(5'd19, "load_use", r19);
    store_result(5'd18, "load_data", load_word);

    // Control flow, flushed slots hold poison stores
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd20, 5'd0, 12'd3));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd21, 5'd0, 12'd3));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd22, 5'd0, POISON[11:0]));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd23, 5'd0, 12'd0));
    emit(b_type(rv_isa_pkg::F3_BEQ, 5'd20, 5'd21, 13'd12));
    store_poison();
    store_poison();
    emit(b_type(rv_isa_pkg::F3_BNE, 5'd20, 5'd21, 13'd8));
    emit(i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 5'd23, 5'd0, 12'h055));
    store_result(5'd23, "bne_untaken", 32'h0000_0055);
    jal_pc = 32'(n_instr * 4);
    emit(j_type(5'd24, 21'd12));
    store_poison();
    store_poison();
    store_result(5'd24, "jal_link", jal_pc + 32'd4);

    // Halt, the stores behind it must never issue
    emit(rv_isa_pkg::I_EBREAK);
    store_poison();
    store_poison();
    store_poison();

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    while (ebreak !== 1'b1) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);

    missing = 0;
    for (int i = 0; i < 128; i++) begin
      if (exp_valid[i] && !seen[i]) begin
        $display("store for %s never happened", test_name[i]);
        missing++;
      end
    end
    if (missing != 0) begin
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
